// ==== Makefile ====
# Verilator flow for the ANTIC register block

VERILATOR ?= verilator
TOP       ?= anticRegsTb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== list.f ====
logic/anticPkg.sv
logic/anticRegDecode.sv
logic/anticRegFile.sv
logic/anticNmiCtrl.sv
logic/anticScanTimer.sv
logic/anticRegsTop.sv
tb/anticRegs_props.sv
tb/anticRegsTb.sv

// ==== logic/anticNmiCtrl.sv ====
//==========================================================================
// ANTIC NMI controller keeping NMIST and pulsing the NMI request line
//==========================================================================
`default_nettype none

module anticNmiCtrl
  import anticPkg::*;
(
  input  logic       clk,
  input  logic       arstN,
  input  logic       dliReq,        // Display list interrupt event
  input  logic       vbiEvent,      // Start of vertical blank
  input  logic       resetKey,      // System reset key event
  input  nmiStatus_t nmiEnable,     // NMIEN mask
  input  logic       nmiResStrobe,  // CPU write to NMIRES
  output nmiStatus_t nmiStatus,     // NMIST
  output logic       nmiReq         // One-cycle NMI request to the CPU
);

  nmiStatus_t events;   // Events of this cycle in NMIST layout
  logic       reqNext;  // Some event of this cycle is enabled

  always_comb begin
    events          = '0;
    events.dli      = dliReq;
    events.vbi      = vbiEvent;
    events.resetKey = resetKey;
  end

  // All three sources are masked by NMIEN the same way
  assign reqNext = (events.dli && nmiEnable.dli)
                || (events.vbi && nmiEnable.vbi)
                || (events.resetKey && nmiEnable.resetKey);

  // Status bits are sticky until NMIRES. An event on the reset edge survives
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      nmiStatus <= '0;
    end else if (nmiResStrobe) begin
      nmiStatus <= events;  // Clear everything except what arrives now
    end else begin
      nmiStatus <= nmiStatus_t'(nmiStatus | events);
    end
  end

  // Each enabled event gives a request in the cycle its status bit is set
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      nmiReq <= 1'b0;
    end else begin
      nmiReq <= reqNext;  // Pulse appears with the status bit
    end
  end

endmodule

`default_nettype wire

// ==== logic/anticPkg.sv ====
//==========================================================================
// ANTIC register block package with register offsets, scan timing and the
// structs shared by the decoder, register file, scan timer and NMI block
//==========================================================================
`default_nettype none

package anticPkg;

  // Frame geometry in machine cycles for an NTSC frame
  localparam int CyclesPerLine = 114;  // Machine cycles in one scanline
  localparam int LinesPerFrame = 262;  // Scanlines in one frame
  localparam int VblankLine    = 248;  // First scanline of vertical blank

  localparam logic [7:0] UnmappedRead = 8'hFF;  // Value seen at the holes in the map

  // CPU register offsets, the low nibble of the $D40x window
  typedef enum logic [3:0] {
    DmaCtl = 4'h0,  // Playfield and player/missile DMA control
    ChaCtl = 4'h1,  // Character inversion and reflection
    DlistL = 4'h2,  // Display list pointer low byte
    DlistH = 4'h3,  // Display list pointer high byte
    HScrol = 4'h4,  // Fine horizontal scroll
    VScrol = 4'h5,  // Fine vertical scroll
    PmBase = 4'h7,  // Player/missile base page
    ChBase = 4'h9,  // Character set base page
    WSync  = 4'hA,  // Halt the CPU until the end of the line
    VCount = 4'hB,  // Half the current line number
    PenH   = 4'hC,  // Light pen horizontal position
    PenV   = 4'hD,  // Light pen vertical position
    NmiEn  = 4'hE,  // NMI enable mask
    NmiRes = 4'hF   // NMI status on read and status reset on write
  } regSel_e;

  // One CPU write after decoding, 13 bits
  typedef struct packed {
    logic       valid;  // Write is aimed at a writable register
    regSel_e    sel;    // Target register
    logic [7:0] data;   // Byte from the CPU data bus
  } regWrite_t;

  // Control registers that steer the display logic, 48 bits
  typedef struct packed {
    logic [7:0] dmaCtl;  // DMACTL
    logic [7:0] chaCtl;  // CHACTL
    logic [7:0] hScrol;  // HSCROL
    logic [7:0] vScrol;  // VSCROL
    logic [7:0] pmBase;  // PMBASE
    logic [7:0] chBase;  // CHBASE
  } anticCtrl_t;

  // Bit layout shared by NMIST and NMIEN
  typedef struct packed {
    logic       dli;       // Bit 7 display list interrupt
    logic       vbi;       // Bit 6 vertical blank interrupt
    logic       resetKey;  // Bit 5 system reset key
    logic [4:0] unused;    // Bits 4 to 0 have no function
  } nmiStatus_t;

endpackage

`default_nettype wire

// ==== logic/anticRegDecode.sv ====
//==========================================================================
// ANTIC CPU write decoder that filters writes down to the writable map
//==========================================================================
`default_nettype none

module anticRegDecode
  import anticPkg::*;
(
  input  logic       cpuWe,      // CPU write enable for this cycle
  input  logic [3:0] cpuAddr,    // Register offset within the window
  input  logic [7:0] cpuWrData,  // CPU write data
  output regWrite_t  regWrite    // Validated write to the register file
);

  regSel_e sel;       // Offset viewed as a register name
  logic    writable;  // Offset accepts a CPU write

  // Offsets 6 and 8 have no enum name but the cast keeps the raw value
  assign sel = regSel_e'(cpuAddr);

  // Three classes of offset. Only the writable class passes
  always_comb begin
    case (sel)
      DmaCtl, ChaCtl, HScrol, VScrol, PmBase, ChBase: begin
        writable = 1'b1;  // Plain control registers
      end
      DlistL, DlistH: begin
        writable = 1'b1;  // Shared with the coprocessor pointer load
      end
      WSync, NmiEn, NmiRes: begin
        writable = 1'b1;  // Timer and interrupt controls
      end
      VCount, PenH, PenV: begin
        writable = 1'b0;  // Read-only values owned by the timer and light pen
      end
      default: begin
        writable = 1'b0;  // Holes at offsets 6 and 8
      end
    endcase
  end

  assign regWrite.valid = cpuWe && writable;  // Dropped writes never reach storage
  assign regWrite.sel   = sel;                // Target travels with the write
  assign regWrite.data  = cpuWrData;          // Data is only meaningful with valid

endmodule

`default_nettype wire

// ==== logic/anticRegFile.sv ====
//==========================================================================
// ANTIC register storage with CPU and coprocessor writes and the CPU read
// multiplexer over stored, timer and interrupt status values
//==========================================================================
`default_nettype none

module anticRegFile
  import anticPkg::*;
(
  input  logic        clk,
  input  logic        arstN,
  input  regWrite_t   regWrite,      // Decoded CPU write
  input  logic [3:0]  cpuAddr,       // CPU read offset
  input  logic        dlistLoad,     // Coprocessor reloads the display list pointer
  input  logic [15:0] dlistIn,       // New display list pointer
  input  logic        penLatch,      // Light pen trigger
  input  logic [7:0]  hPos,          // Current cycle within the line
  input  logic [7:0]  vcount,        // Current line divided by 2
  input  nmiStatus_t  nmiStatus,     // NMIST from the interrupt block
  output logic [7:0]  cpuRdData,     // Combinational CPU read data
  output anticCtrl_t  ctrl,          // Control registers for the display logic
  output logic [15:0] dlistPtr,      // DLISTH and DLISTL together
  output nmiStatus_t  nmiEnable,     // Stored NMIEN
  output logic        wsyncStrobe,   // CPU wrote WSYNC this cycle
  output logic        nmiResStrobe   // CPU wrote NMIRES this cycle
);

  logic [7:0] wsyncQ;  // Last byte written to WSYNC, returned on read
  logic [7:0] penH;    // Latched light pen cycle
  logic [7:0] penV;    // Latched light pen line pair

  // CPU writes are assigned after the pointer load so a CPU byte overrides
  // the same byte of dlistIn while the other byte still takes the load
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctrl      <= '0;
      dlistPtr  <= '0;
      nmiEnable <= '0;
      wsyncQ    <= '0;
    end else begin
      if (dlistLoad) begin
        dlistPtr <= dlistIn;  // Coprocessor load of both bytes
      end
      if (regWrite.valid) begin
        case (regWrite.sel)
          DmaCtl:  ctrl.dmaCtl     <= regWrite.data;
          ChaCtl:  ctrl.chaCtl     <= regWrite.data;
          HScrol:  ctrl.hScrol     <= regWrite.data;
          VScrol:  ctrl.vScrol     <= regWrite.data;
          PmBase:  ctrl.pmBase     <= regWrite.data;
          ChBase:  ctrl.chBase     <= regWrite.data;
          DlistL:  dlistPtr[7:0]   <= regWrite.data;  // CPU wins the low byte
          DlistH:  dlistPtr[15:8]  <= regWrite.data;  // CPU wins the high byte
          WSync:   wsyncQ          <= regWrite.data;
          NmiEn:   nmiEnable       <= nmiStatus_t'(regWrite.data);
          default: ;  // NMIRES only produces its strobe
        endcase
      end
    end
  end

  // Light pen position sampled from the live beam counters
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      penH <= '0;
      penV <= '0;
    end else if (penLatch) begin
      penH <= hPos;    // Cycle of the trigger
      penV <= vcount;  // Line pair of the trigger
    end
  end

  // Strobes fire in the write cycle so the consumers act on the write edge
  assign wsyncStrobe  = regWrite.valid && (regWrite.sel == WSync);
  assign nmiResStrobe = regWrite.valid && (regWrite.sel == NmiRes);

  always_comb begin
    case (regSel_e'(cpuAddr))
      DmaCtl:  cpuRdData = ctrl.dmaCtl;
      ChaCtl:  cpuRdData = ctrl.chaCtl;
      DlistL:  cpuRdData = dlistPtr[7:0];
      DlistH:  cpuRdData = dlistPtr[15:8];
      HScrol:  cpuRdData = ctrl.hScrol;
      VScrol:  cpuRdData = ctrl.vScrol;
      PmBase:  cpuRdData = ctrl.pmBase;
      ChBase:  cpuRdData = ctrl.chBase;
      WSync:   cpuRdData = wsyncQ;
      VCount:  cpuRdData = vcount;     // Live from the scan timer
      PenH:    cpuRdData = penH;
      PenV:    cpuRdData = penV;
      NmiEn:   cpuRdData = nmiEnable;
      NmiRes:  cpuRdData = nmiStatus;  // Reads return NMIST
      default: cpuRdData = UnmappedRead;  // Offsets 6 and 8
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/anticRegsTop.sv ====
//==========================================================================
// ANTIC register block top joining decode, storage, scan timer and NMI
//==========================================================================
`default_nettype none

module anticRegsTop
  import anticPkg::*;
(
  input  logic        clk,
  input  logic        arstN,
  input  logic        cpuWe,      // CPU write enable
  input  logic [3:0]  cpuAddr,    // CPU register offset
  input  logic [7:0]  cpuWrData,  // CPU write data
  input  logic        dlistLoad,  // Display list pointer reload
  input  logic [15:0] dlistIn,    // Reload value
  input  logic        penLatch,   // Light pen trigger
  input  logic        dliReq,     // Display list interrupt event
  input  logic        resetKey,   // Reset key event
  output logic [7:0]  cpuRdData,  // CPU read data
  output anticCtrl_t  ctrl,       // Control registers for the display logic
  output logic [15:0] dlistPtr,   // Display list pointer
  output logic        haltCpu,    // WSYNC halt
  output logic        nmiReq,     // NMI request pulse
  output logic [7:0]  vcount      // Current line divided by 2
);

  regWrite_t  regWrite;      // Decoded CPU write
  logic [7:0] hPos;          // Cycle within the line
  logic       vbiEvent;      // Vertical blank start
  logic       wsyncStrobe;   // WSYNC write
  logic       nmiResStrobe;  // NMIRES write
  nmiStatus_t nmiStatus;     // NMIST
  nmiStatus_t nmiEnable;     // NMIEN

  anticRegDecode decode_i (
    .cpuWe     (cpuWe),
    .cpuAddr   (cpuAddr),
    .cpuWrData (cpuWrData),
    .regWrite  (regWrite)
  );

  anticRegFile regFile_i (
    .clk          (clk),
    .arstN        (arstN),
    .regWrite     (regWrite),
    .cpuAddr      (cpuAddr),
    .dlistLoad    (dlistLoad),
    .dlistIn      (dlistIn),
    .penLatch     (penLatch),
    .hPos         (hPos),
    .vcount       (vcount),
    .nmiStatus    (nmiStatus),
    .cpuRdData    (cpuRdData),
    .ctrl         (ctrl),
    .dlistPtr     (dlistPtr),
    .nmiEnable    (nmiEnable),
    .wsyncStrobe  (wsyncStrobe),
    .nmiResStrobe (nmiResStrobe)
  );

  anticScanTimer timer_i (
    .clk         (clk),
    .arstN       (arstN),
    .wsyncStrobe (wsyncStrobe),
    .hPos        (hPos),
    .vcount      (vcount),
    .vbiEvent    (vbiEvent),
    .haltCpu     (haltCpu)
  );

  anticNmiCtrl nmi_i (
    .clk          (clk),
    .arstN        (arstN),
    .dliReq       (dliReq),
    .vbiEvent     (vbiEvent),
    .resetKey     (resetKey),
    .nmiEnable    (nmiEnable),
    .nmiResStrobe (nmiResStrobe),
    .nmiStatus    (nmiStatus),
    .nmiReq       (nmiReq)
  );

endmodule

`default_nettype wire

// ==== logic/anticScanTimer.sv ====
//==========================================================================
// ANTIC scan timer with cycle and line counters, VCOUNT, vertical blank
// event and the WSYNC CPU halt
//==========================================================================
`default_nettype none

module anticScanTimer
  import anticPkg::*;
(
  input  logic       clk,
  input  logic       arstN,
  input  logic       wsyncStrobe,  // CPU wrote WSYNC
  output logic [7:0] hPos,         // Machine cycle within the line
  output logic [7:0] vcount,       // Line number divided by 2
  output logic       vbiEvent,     // First cycle of the vertical blank line
  output logic       haltCpu       // CPU must wait for the end of the line
);

  logic [8:0] line;      // Scanline within the frame
  logic       lineEnd;   // Last cycle of the scanline
  logic       frameEnd;  // Last scanline of the frame

  assign lineEnd  = (hPos == 8'(CyclesPerLine - 1));
  assign frameEnd = (line == 9'(LinesPerFrame - 1));

  // Horizontal counter wraps every line
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      hPos <= '0;
    end else if (lineEnd) begin
      hPos <= '0;
    end else begin
      hPos <= hPos + 8'd1;
    end
  end

  // Line counter steps on each horizontal wrap
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      line <= '0;
    end else if (lineEnd) begin
      line <= frameEnd ? 9'd0 : line + 9'd1;
    end
  end

  assign vcount = line[8:1];  // Peaks at 130 on line 261

  // One cycle wide since hPos only sits at 0 for a single cycle
  assign vbiEvent = (line == 9'(VblankLine)) && (hPos == 8'd0);

  // Line end beats a WSYNC in the same cycle, so the halt is gone when hPos is 0
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      haltCpu <= 1'b0;
    end else if (lineEnd) begin
      haltCpu <= 1'b0;  // Release at the horizontal wrap
    end else if (wsyncStrobe) begin
      haltCpu <= 1'b1;  // A repeat write while halted changes nothing
    end
  end

endmodule

`default_nettype wire

// ==== tb/anticRegsTb.sv ====
//==========================================================================
// Directed testbench for the ANTIC register block covering CPU access,
// pointer loads, WSYNC halts, NMI status and the VCOUNT sweep
//==========================================================================
`default_nettype none

module anticRegsTb
  import anticPkg::*;
();

  logic        clk;
  logic        arstN;
  logic        cpuWe;      // CPU write enable
  logic [3:0]  cpuAddr;    // CPU register offset
  logic [7:0]  cpuWrData;  // CPU write data
  logic        dlistLoad;  // Coprocessor pointer reload
  logic [15:0] dlistIn;    // Reload value
  logic        penLatch;   // Light pen trigger
  logic        dliReq;     // Display list interrupt event
  logic        resetKey;   // Reset key event
  logic [7:0]  cpuRdData;
  anticCtrl_t  ctrl;
  logic [15:0] dlistPtr;
  logic        haltCpu;
  logic        nmiReq;
  logic [7:0]  vcount;

  int    errors;    // Failed checks
  int    checks;    // Checks performed
  string testName;  // Test that is running

  anticRegsTop dut_i (
    .clk       (clk),
    .arstN     (arstN),
    .cpuWe     (cpuWe),
    .cpuAddr   (cpuAddr),
    .cpuWrData (cpuWrData),
    .dlistLoad (dlistLoad),
    .dlistIn   (dlistIn),
    .penLatch  (penLatch),
    .dliReq    (dliReq),
    .resetKey  (resetKey),
    .cpuRdData (cpuRdData),
    .ctrl      (ctrl),
    .dlistPtr  (dlistPtr),
    .haltCpu   (haltCpu),
    .nmiReq    (nmiReq),
    .vcount    (vcount)
  );

  always #10 clk = ~clk;  // Period of 20

  task automatic checkByte(input string what, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s %s: expected %h, actual %h", testName, what, exp, act);
    end
  endtask

  task automatic checkPtr(input string what, input logic [15:0] exp, input logic [15:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s %s: expected %h, actual %h", testName, what, exp, act);
    end
  endtask

  task automatic checkCtrl(input string what, input anticCtrl_t exp, input anticCtrl_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s %s: expected %h, actual %h", testName, what, exp, act);
    end
  endtask

  task automatic checkStatus(input string what, input nmiStatus_t exp, input nmiStatus_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s %s: expected %h, actual %h", testName, what, exp, act);
    end
  endtask

  task automatic checkFlag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s %s: expected %b, actual %b", testName, what, exp, act);
    end
  endtask

  // One write edge, returns on the falling edge after it
  task automatic cpuWrite(input logic [3:0] addr, input logic [7:0] data);
    @(negedge clk);
    cpuWe     = 1'b1;
    cpuAddr   = addr;
    cpuWrData = data;
    @(negedge clk);
    cpuWe = 1'b0;
  endtask

  task automatic cpuReadCheck(input logic [3:0] addr, input logic [7:0] exp, input string what);
    @(negedge clk);
    cpuWe   = 1'b0;
    cpuAddr = addr;
    #1;  // Let the read mux settle
    checkByte(what, exp, cpuRdData);
  endtask

  task automatic testRegisters();
    anticCtrl_t  expCtrl;  // Model of the control registers
    logic [15:0] expPtr;   // Model of the display list pointer
    logic [7:0]  data;
    regSel_e     sel;
    testName = "testRegisters";
    expCtrl  = '0;
    expPtr   = '0;
    for (int a = 0; a < 16; a++) begin
      sel  = regSel_e'(4'(a));
      data = 8'($urandom);
      case (sel)
        DmaCtl:      expCtrl.dmaCtl = data;
        ChaCtl:      expCtrl.chaCtl = data;
        HScrol:      expCtrl.hScrol = data;
        VScrol:      expCtrl.vScrol = data;
        PmBase:      expCtrl.pmBase = data;
        ChBase:      expCtrl.chBase = data;
        DlistL:      expPtr[7:0]    = data;
        DlistH:      expPtr[15:8]   = data;
        WSync, NmiEn: ;             // Stored but outside ctrl
        default:     continue;      // Read-only, holes and NMIRES
      endcase
      cpuWrite(sel, data);
      cpuReadCheck(sel, data, $sformatf("offset %0h", a));
    end
    checkCtrl("ctrl", expCtrl, ctrl);
    checkPtr("dlistPtr", expPtr, dlistPtr);
    cpuWrite(VCount, 8'h3C);  // None of these may land anywhere
    cpuWrite(PenH, 8'h5A);
    cpuWrite(PenV, 8'hA5);
    cpuWrite(4'h6, 8'h12);
    cpuWrite(4'h8, 8'h34);
    checkCtrl("ctrl after dropped writes", expCtrl, ctrl);
    checkPtr("dlistPtr after dropped writes", expPtr, dlistPtr);
    cpuReadCheck(PenH, 8'h00, "PENH");
    cpuReadCheck(PenV, 8'h00, "PENV");
    cpuReadCheck(4'h6, 8'hFF, "offset 6");
    cpuReadCheck(4'h8, 8'hFF, "offset 8");
  endtask

  task automatic testDlistPriority();
    logic [15:0] v1;
    logic [15:0] v2;
    logic [7:0]  b;
    testName = "testDlistPriority";
    v1 = 16'($urandom);
    v2 = 16'($urandom);
    b  = 8'($urandom);
    @(negedge clk);
    dlistLoad = 1'b1;
    dlistIn   = v1;
    @(negedge clk);
    dlistLoad = 1'b0;
    checkPtr("load", v1, dlistPtr);
    dlistLoad = 1'b1;  // Load and CPU low byte meet on one edge
    dlistIn   = v2;
    cpuWe     = 1'b1;
    cpuAddr   = DlistL;
    cpuWrData = b;
    @(negedge clk);
    dlistLoad = 1'b0;
    cpuWe     = 1'b0;
    checkPtr("load with CPU write", {v2[15:8], b}, dlistPtr);
    cpuReadCheck(DlistL, b, "DLISTL");
    cpuReadCheck(DlistH, v2[15:8], "DLISTH");
  endtask

  task automatic testWsync();
    logic [7:0] startV;
    int         cnt;
    testName = "testWsync";
    startV   = vcount;
    while (vcount == startV) begin
      @(negedge clk);  // Ends on the first cycle of an even line
    end
    cpuWrite(WSync, 8'h5A);
    checkFlag("haltCpu after WSYNC", 1'b1, haltCpu);
    cpuWrite(WSync, 8'hA5);
    checkFlag("haltCpu after second WSYNC", 1'b1, haltCpu);
    cnt = 2;  // Cycles 2 and 3 of the line were already halted
    while (haltCpu && cnt <= CyclesPerLine) begin
      cnt++;
      @(negedge clk);
    end
    checkByte("halt cycles", 8'(CyclesPerLine - 2), 8'(cnt));  // Halt began at cycle 2
    checkFlag("haltCpu after line end", 1'b0, haltCpu);
    cpuReadCheck(WSync, 8'hA5, "WSYNC readback");
  endtask

  task automatic waitVbi(input logic expReq);
    nmiStatus_t st;
    st = '0;
    @(negedge clk);
    cpuAddr = NmiRes;
    while (!st.vbi) begin
      @(negedge clk);
      st = nmiStatus_t'(cpuRdData);
    end
    checkFlag("nmiReq with VBI status", expReq, nmiReq);  // Same cycle as the bit
  endtask

  task automatic testNmi();
    nmiStatus_t expSt;
    testName = "testNmi";
    expSt    = '0;
    cpuWrite(NmiEn, 8'h40);
    cpuWrite(NmiRes, 8'h00);
    cpuReadCheck(NmiRes, 8'h00, "NMIST cleared");
    waitVbi(1'b1);
    expSt.vbi = 1'b1;
    checkStatus("NMIST after enabled VBI", expSt, nmiStatus_t'(cpuRdData));
    cpuWrite(NmiEn, 8'h00);
    cpuWrite(NmiRes, 8'h00);
    waitVbi(1'b0);
    checkStatus("NMIST after masked VBI", expSt, nmiStatus_t'(cpuRdData));
    @(negedge clk);
    dliReq = 1'b1;
    @(negedge clk);
    dliReq    = 1'b0;
    expSt.dli = 1'b1;
    checkFlag("nmiReq on masked DLI", 1'b0, nmiReq);
    checkStatus("NMIST after DLI", expSt, nmiStatus_t'(cpuRdData));
    cpuWe     = 1'b1;  // NMIRES and the reset key share one edge
    cpuWrData = 8'h00;
    resetKey  = 1'b1;
    @(negedge clk);
    cpuWe    = 1'b0;
    resetKey = 1'b0;
    expSt    = '0;
    expSt.resetKey = 1'b1;
    checkStatus("NMIST after NMIRES with reset key", expSt, nmiStatus_t'(cpuRdData));
  endtask

  task automatic testVcountPen();
    logic [7:0] maxV;
    logic [7:0] penVExp;
    logic [7:0] penHExp;
    testName = "testVcountPen";
    maxV     = '0;
    penVExp  = '0;
    penHExp  = '0;
    while (vcount == 8'd0) begin
      @(negedge clk);
    end
    while (vcount != 8'd0) begin
      @(negedge clk);  // Stops on cycle 0 of line 0
    end
    for (int cyc = 0; cyc < LinesPerFrame * CyclesPerLine; cyc++) begin
      checkByte("vcount", 8'((cyc / CyclesPerLine) / 2), vcount);
      if (vcount > maxV) maxV = vcount;
      penLatch = (cyc == 150 * CyclesPerLine + 57);
      if (penLatch) begin
        penVExp = 8'((cyc / CyclesPerLine) / 2);  // Value the CPU would read now
        penHExp = 8'(cyc % CyclesPerLine);
      end
      @(negedge clk);
    end
    penLatch = 1'b0;
    checkByte("vcount peak", 8'((LinesPerFrame - 1) / 2), maxV);
    checkByte("vcount after frame", 8'd0, vcount);
    cpuReadCheck(PenV, penVExp, "PENV");
    cpuReadCheck(PenH, penHExp, "PENH");
  endtask

  initial begin
    clk       = 1'b0;
    arstN     = 1'b0;
    cpuWe     = 1'b0;
    cpuAddr   = '0;
    cpuWrData = '0;
    dlistLoad = 1'b0;
    dlistIn   = '0;
    penLatch  = 1'b0;
    dliReq    = 1'b0;
    resetKey  = 1'b0;
    errors    = 0;
    checks    = 0;
    testName  = "reset";
    void'($urandom(8273));
    repeat (10) @(negedge clk);
    arstN = 1'b1;
    checkCtrl("ctrl", '0, ctrl);
    checkFlag("haltCpu", 1'b0, haltCpu);
    testRegisters();
    testDlistPriority();
    testWsync();
    testNmi();
    testVcountPen();
    $display("Checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Three frames cover the VBI waits and the VCOUNT sweep
  initial begin
    repeat (3 * LinesPerFrame * CyclesPerLine + 20 * CyclesPerLine) @(posedge clk);
    $display("Timeout: the tests did not finish in the expected number of cycles");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/anticRegs_props.sv ====
//==========================================================================
// Concurrent assertions on NMI pulses, WSYNC release and the VCOUNT range
//==========================================================================
`default_nettype none

module anticRegsProps
  import anticPkg::*;
(
  input logic       clk,
  input logic       arstN,
  input logic       nmiReq,   // NMI request pulse
  input logic       haltCpu,  // WSYNC halt
  input logic [7:0] hPos,     // Cycle within the line
  input logic [7:0] vcount    // Line divided by 2
);

  nmiReqPulse: assert property (@(posedge clk) disable iff (!arstN) nmiReq |=> !nmiReq)
    else $error("nmiReq was high for more than one cycle");

  // The halt drops on the same edge that wraps hPos
  haltReleased: assert property (@(posedge clk) disable iff (!arstN) (hPos == 8'd0) |-> !haltCpu)
    else $error("haltCpu still high on the first cycle of a line");

  vcountRange: assert property (@(posedge clk) disable iff (!arstN)
    vcount < 8'(LinesPerFrame / 2))
    else $error("vcount reached half the lines per frame");

endmodule

bind anticRegsTop anticRegsProps props_i (
  .clk     (clk),
  .arstN   (arstN),
  .nmiReq  (nmiReq),
  .haltCpu (haltCpu),
  .hPos    (hPos),
  .vcount  (vcount)
);

`default_nettype wire
